/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_video_playfield
RTL_TOP    := video_playfield
FILELIST   := sources.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sources.f */
rtl/playfield_pkg.sv
rtl/bitmap_fetch.sv
rtl/pixel_expand.sv
rtl/line_sequencer.sv
rtl/pixel_scanout.sv
rtl/video_playfield.sv
testbench/video_playfield_chk.sv
testbench/tb_video_playfield.sv

/* testbench/tb_video_playfield.sv */
`timescale 1ns/1ps

module tb_video_playfield;
    import playfield_pkg::*;

    localparam int H_TOTAL         = 1024;              // pixels per line
    localparam int LINES_PER_FRAME = 5;                 // line 0 of each frame runs blanked
    localparam int NUM_FRAMES      = 4;
    localparam int FETCH_START_H   = 40;                // mem_fetch_start position
    localparam int FETCH_END_H     = 900;
    localparam int FRAME_TIMEOUT   = H_TOTAL * LINES_PER_FRAME + 100;
    localparam int LINE_TIMEOUT    = H_TOTAL + 100;
    localparam int READ_TIMEOUT    = 256;
    localparam int unsigned SEED   = 37435;

    logic        clk;
    logic        reset_i;
    logic        stall_i           = 1'b0;
    hres_t       h_count_i         = '0;
    logic        mem_fetch_i       = 1'b0;
    logic        mem_fetch_start_i = 1'b0;
    logic        end_of_line_i     = 1'b0;
    logic        end_of_frame_i    = 1'b0;
    color_t      border_color_i;
    hres_t       vid_left_i;
    hres_t       vid_right_i;
    logic        vram_sel_o;
    addr_t       vram_addr_o;
    word_t       vram_data_i       = '0;
    logic        pf_blank_i;
    addr_t       pf_start_addr_i;
    word_t       pf_line_len_i;
    color_t      pf_colorbase_i;
    logic [1:0]  pf_bpp_i;
    logic [1:0]  pf_h_repeat_i;
    logic [1:0]  pf_v_repeat_i;
    color_t      pf_color_index_o;
    int          v_line            = 0;                 // line within frame
    int unsigned stall_state       = SEED;              // stall generator state
    int unsigned cfg_state         = SEED;              // config generator state
    int          timeout_cnt;
    int          check_errors;

    video_playfield DUT (.*);

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                         // 40 ns period
    end

    // line timing and random memory contention
    always @(posedge clk) begin
        stall_state <= lcg_next(stall_state);
        stall_i     <= (stall_state[29:28] == 2'b00);   // about one cycle in four
        if (reset_i) begin
            h_count_i         <= '0;
            v_line            <= 0;
            end_of_line_i     <= 1'b0;
            end_of_frame_i    <= 1'b0;
            mem_fetch_start_i <= 1'b0;
            mem_fetch_i       <= 1'b0;
        end else begin
            if (h_count_i == hres_t'(H_TOTAL - 1)) begin
                h_count_i <= '0;
                v_line    <= (v_line == LINES_PER_FRAME - 1) ? 0 : v_line + 1;
            end else begin
                h_count_i <= h_count_i + 11'd1;
            end
            end_of_line_i     <= (h_count_i == hres_t'(H_TOTAL - 2));
            end_of_frame_i    <= (h_count_i == hres_t'(H_TOTAL - 2)) &&
                                 (v_line == LINES_PER_FRAME - 1);
            mem_fetch_start_i <= (h_count_i == hres_t'(FETCH_START_H - 1));
            mem_fetch_i       <= (h_count_i >= hres_t'(FETCH_START_H - 1)) &&
                                 (h_count_i < hres_t'(FETCH_END_H - 1));
        end
    end

    // vram answers by the next edge, holds its data through a stall
    always @(posedge clk) begin
        if (vram_sel_o && !stall_i) begin
            vram_data_i <= vram_addr_o ^ 16'h5A5A;
        end
    end

    task automatic wait_frame_end();
        int n = 0;
        while (n < FRAME_TIMEOUT) begin
            @(posedge clk);
            if (end_of_frame_i) break;
            n++;
        end
        if (n == FRAME_TIMEOUT) begin
            timeout_cnt++;
            $display("timeout: no end of frame within %0d cycles", FRAME_TIMEOUT);
        end
    endtask

    task automatic wait_line_end();
        int n = 0;
        while (n < LINE_TIMEOUT) begin
            @(posedge clk);
            if (end_of_line_i) break;
            n++;
        end
        if (n == LINE_TIMEOUT) begin
            timeout_cnt++;
            $display("timeout: no end of line within %0d cycles", LINE_TIMEOUT);
        end
    endtask

    task automatic wait_first_read();
        int n = 0;
        while (n < READ_TIMEOUT) begin
            @(posedge clk);
            if (vram_sel_o) break;
            n++;
        end
        if (n == READ_TIMEOUT) begin
            timeout_cnt++;
            $display("timeout: no vram read within %0d cycles of unblank", READ_TIMEOUT);
        end
    endtask

    // new depth, repeats and start address, blanked for one line
    task automatic pick_config();
        cfg_state = lcg_next(cfg_state);
        pf_bpp_i        <= cfg_state[31:30];            // code 3 runs as 8 bpp
        pf_h_repeat_i   <= cfg_state[29:28];
        pf_v_repeat_i   <= cfg_state[27:26];
        cfg_state = lcg_next(cfg_state);
        pf_start_addr_i <= addr_t'(cfg_state[31:16]);
        pf_blank_i      <= 1'b1;
    endtask

    initial begin
        reset_i         = 1'b1;
        pf_blank_i      = 1'b1;                         // first frame fully blanked
        border_color_i  = 8'h3C;
        pf_colorbase_i  = 8'h81;
        vid_left_i      = 11'd16;                       // fixed window
        vid_right_i     = 11'd336;
        pf_start_addr_i = '0;
        pf_line_len_i   = 16'd40;
        pf_bpp_i        = BPP_1_ATTR;
        pf_h_repeat_i   = 2'd0;
        pf_v_repeat_i   = 2'd0;
        timeout_cnt     = 0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        for (int f = 0; f < NUM_FRAMES && timeout_cnt == 0; f++) begin
            wait_frame_end();
            if (timeout_cnt == 0) begin
                pick_config();
                wait_line_end();
                pf_blank_i <= 1'b0;                     // active from next line
                wait_first_read();
            end
        end
        if (timeout_cnt == 0) begin
            wait_frame_end();                           // let the last frame finish
        end
        check_errors = DUT.u_chk.err_cnt;
        $display("closing: %0d assertion failures, %0d timeouts", check_errors, timeout_cnt);
        if (check_errors == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* testbench/video_playfield_chk.sv */
`timescale 1ns/1ps

module video_playfield_chk (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  playfield_pkg::hres_t  h_count_i,
    input  logic                  mem_fetch_start_i,
    input  logic                  end_of_line_i,
    input  logic                  end_of_frame_i,
    input  playfield_pkg::color_t border_color_i,
    input  playfield_pkg::hres_t  vid_left_i,
    input  logic                  vram_sel_i,           // DUT read strobe
    input  playfield_pkg::addr_t  vram_addr_i,          // DUT read address
    input  logic                  pf_blank_i,
    input  playfield_pkg::addr_t  pf_start_addr_i,
    input  playfield_pkg::word_t  pf_line_len_i,
    input  playfield_pkg::color_t pf_colorbase_i,
    input  logic [1:0]            pf_bpp_i,
    input  logic [1:0]            pf_v_repeat_i,
    input  playfield_pkg::color_t color_index_i         // DUT output color
);
    import playfield_pkg::*;

    int         err_cnt = 0;                            // failed assertions so far
    addr_t      exp_addr;                               // next read address expected
    addr_t      model_line;                             // model line start address
    logic [1:0] lines_done;                             // lines shown at this line start
    logic       in_line;                                // read sequence is predictable
    int         read_cnt;                               // reads since last end of line
    int         group_len;                              // reads per group for this depth
    logic       read_seen;                              // one read lands this edge
    logic       restart;                                // frame start or blank

    assign read_seen = vram_sel_i && !stall_i;
    assign restart   = pf_blank_i || end_of_frame_i;
    assign group_len = (pf_bpp_i == BPP_1_ATTR) ? 1 : ((pf_bpp_i == BPP_4) ? 2 : 4);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exp_addr   <= '0;
            model_line <= '0;
            lines_done <= '0;
            in_line    <= 1'b0;
            read_cnt   <= 0;
        end else begin
            if (read_seen) begin
                exp_addr <= exp_addr + 16'd1;
                read_cnt <= read_cnt + 1;
            end
            if (end_of_line_i) begin
                in_line  <= 1'b0;                       // address unknown until fetch start
                read_cnt <= 0;
                if (lines_done == pf_v_repeat_i) begin
                    lines_done <= '0;
                    model_line <= model_line + pf_line_len_i;
                end else begin
                    lines_done <= lines_done + 2'd1;    // repeat same line
                end
            end
            if (mem_fetch_start_i) begin
                in_line  <= 1'b1;
                exp_addr <= model_line;
            end
            if (restart) begin
                in_line    <= 1'b1;                     // fetch resumes at frame start
                exp_addr   <= pf_start_addr_i;
                model_line <= pf_start_addr_i;
                lines_done <= '0;
                read_cnt   <= 0;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        reset_i |=> !vram_sel_i && color_index_i == pf_colorbase_i)
        else begin err_cnt++; $error("MISMATCH %0t: outputs after reset", $time); end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        stall_i && !pf_blank_i |=> $stable(vram_sel_i) && $stable(vram_addr_i))
        else begin err_cnt++; $error("MISMATCH %0t: vram outputs moved in stall", $time); end

    a_read_addr: assert property (@(posedge clk) disable iff (reset_i)
        read_seen && in_line |-> vram_addr_i == exp_addr)
        else begin
            err_cnt++;
            $error("MISMATCH %0t: read address %h, expected %h", $time, vram_addr_i, exp_addr);
        end

    a_group_reads: assert property (@(posedge clk) disable iff (reset_i)
        end_of_line_i |-> (read_cnt % group_len) == 0)
        else begin err_cnt++; $error("MISMATCH %0t: %0d reads in line", $time, read_cnt); end

    a_blank_out: assert property (@(posedge clk) disable iff (reset_i)
        pf_blank_i && $past(pf_blank_i) |=>
            !vram_sel_i && color_index_i == (border_color_i ^ pf_colorbase_i))
        else begin err_cnt++; $error("MISMATCH %0t: output while blanked", $time); end

    a_left_border: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) && h_count_i < hres_t'(vid_left_i + H_SCANOUT_BEGIN) |->
            color_index_i == (border_color_i ^ pf_colorbase_i))
        else begin err_cnt++; $error("MISMATCH %0t: border left of window", $time); end

endmodule

bind video_playfield video_playfield_chk u_chk (
    .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .h_count_i(h_count_i),
    .mem_fetch_start_i(mem_fetch_start_i), .end_of_line_i(end_of_line_i),
    .end_of_frame_i(end_of_frame_i), .border_color_i(border_color_i),
    .vid_left_i(vid_left_i), .vram_sel_i(vram_sel_o), .vram_addr_i(vram_addr_o),
    .pf_blank_i(pf_blank_i), .pf_start_addr_i(pf_start_addr_i),
    .pf_line_len_i(pf_line_len_i), .pf_colorbase_i(pf_colorbase_i), .pf_bpp_i(pf_bpp_i),
    .pf_v_repeat_i(pf_v_repeat_i), .color_index_i(pf_color_index_o)
);

/* rtl/video_playfield.sv */
`timescale 1ns/1ps

module video_playfield (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,              // memory contention this cycle
    input  playfield_pkg::hres_t  h_count_i,
    input  logic                  mem_fetch_i,          // fetch window enable
    input  logic                  mem_fetch_start_i,    // line fetch start strobe
    input  logic                  end_of_line_i,
    input  logic                  end_of_frame_i,
    input  playfield_pkg::color_t border_color_i,
    input  playfield_pkg::hres_t  vid_left_i,           // leftmost visible pixel
    input  playfield_pkg::hres_t  vid_right_i,          // right edge + 1
    output logic                  vram_sel_o,
    output playfield_pkg::addr_t  vram_addr_o,
    input  playfield_pkg::word_t  vram_data_i,
    input  logic                  pf_blank_i,           // plane disabled
    input  playfield_pkg::addr_t  pf_start_addr_i,      // frame start word address
    input  playfield_pkg::word_t  pf_line_len_i,        // words per line
    input  playfield_pkg::color_t pf_colorbase_i,       // xor'd onto every output index
    input  logic [1:0]            pf_bpp_i,
    input  logic [1:0]            pf_h_repeat_i,
    input  logic [1:0]            pf_v_repeat_i,
    output playfield_pkg::color_t pf_color_index_o
);
    import playfield_pkg::*;

    addr_t   line_addr;                                 // sequencer -> fetch
    logic    addr_load;
    logic    line_start;
    logic    scanout_on;                                // sequencer -> scanout
    logic    words_ready;                               // fetch -> expand
    word_t   attr_word;
    word_t   data_word0;
    word_t   data_word1;
    word_t   data_word2;
    word_t   data_word3;
    logic    buf_full;                                  // expand -> fetch back-pressure
    logic    buf_take;                                  // scanout -> expand
    pixels_t pixels_buf;

    bitmap_fetch u_fetch (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .pf_blank_i(pf_blank_i),
        .pf_bpp_i(pf_bpp_i), .buf_full_i(buf_full), .line_start_i(line_start),
        .end_of_line_i(end_of_line_i), .addr_load_i(addr_load), .line_addr_i(line_addr),
        .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .words_ready_o(words_ready), .attr_word_o(attr_word),
        .data_word0_o(data_word0), .data_word1_o(data_word1),
        .data_word2_o(data_word2), .data_word3_o(data_word3)
    );

    pixel_expand u_expand (
        .clk(clk), .reset_i(reset_i), .pf_bpp_i(pf_bpp_i), .words_ready_i(words_ready),
        .attr_word_i(attr_word), .data_word0_i(data_word0), .data_word1_i(data_word1),
        .data_word2_i(data_word2), .data_word3_i(data_word3), .line_start_i(line_start),
        .buf_take_i(buf_take), .buf_full_o(buf_full), .pixels_buf_o(pixels_buf)
    );

    line_sequencer u_seq (
        .clk(clk), .reset_i(reset_i), .h_count_i(h_count_i), .mem_fetch_i(mem_fetch_i),
        .mem_fetch_start_i(mem_fetch_start_i), .end_of_line_i(end_of_line_i),
        .end_of_frame_i(end_of_frame_i), .pf_blank_i(pf_blank_i),
        .vid_left_i(vid_left_i), .vid_right_i(vid_right_i),
        .pf_start_addr_i(pf_start_addr_i), .pf_line_len_i(pf_line_len_i),
        .pf_v_repeat_i(pf_v_repeat_i), .line_addr_o(line_addr), .addr_load_o(addr_load),
        .line_start_o(line_start), .scanout_on_o(scanout_on)
    );

    pixel_scanout u_scanout (
        .clk(clk), .reset_i(reset_i), .scanout_on_i(scanout_on), .pixels_buf_i(pixels_buf),
        .pf_h_repeat_i(pf_h_repeat_i), .border_color_i(border_color_i),
        .pf_colorbase_i(pf_colorbase_i), .buf_take_o(buf_take),
        .pf_color_index_o(pf_color_index_o)
    );

endmodule

/* rtl/pixel_scanout.sv */
`timescale 1ns/1ps

module pixel_scanout (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   scanout_on_i,
    input  playfield_pkg::pixels_t pixels_buf_i,
    input  logic [1:0]             pf_h_repeat_i,
    input  playfield_pkg::color_t  border_color_i,
    input  playfield_pkg::color_t  pf_colorbase_i,
    output logic                   buf_take_o,          // buffer loaded this cycle
    output playfield_pkg::color_t  pf_color_index_o
);
    import playfield_pkg::*;

    logic       on_q;                                   // scanout_on last cycle
    logic       start;                                  // first cycle of scanout
    logic       step;                                   // advance to next pixel
    logic [1:0] h_cnt;                                  // repeat countdown
    logic [2:0] pix_x;                                  // pixel within group
    pixels_t    pixels;                                 // shift register, output on top

    assign start            = scanout_on_i && !on_q;
    assign step             = scanout_on_i && on_q && (h_cnt == 2'd0);
    assign buf_take_o       = start || (step && pix_x == 3'd7);
    assign pf_color_index_o = pixels[63:56] ^ pf_colorbase_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            on_q   <= 1'b0;
            h_cnt  <= '0;
            pix_x  <= '0;
            pixels <= '0;
        end else begin
            on_q <= scanout_on_i;
            if (start) begin
                h_cnt  <= pf_h_repeat_i;
                pix_x  <= 3'd0;
                pixels <= pixels_buf_i;                 // first eight pixels
            end else if (step) begin
                h_cnt <= pf_h_repeat_i;
                pix_x <= pix_x + 1'b1;
                if (pix_x == 3'd7) begin
                    pixels <= pixels_buf_i;             // next group
                end else begin
                    pixels <= {pixels[55:0], border_color_i};
                end
            end else if (scanout_on_i) begin
                h_cnt <= h_cnt - 1'b1;                  // hold current pixel
            end else begin
                pixels[63:56] <= border_color_i;        // border outside window
            end
        end
    end

endmodule

/* rtl/line_sequencer.sv */
`timescale 1ns/1ps

module line_sequencer (
    input  logic                 clk,
    input  logic                 reset_i,
    input  playfield_pkg::hres_t h_count_i,
    input  logic                 mem_fetch_i,
    input  logic                 mem_fetch_start_i,
    input  logic                 end_of_line_i,
    input  logic                 end_of_frame_i,
    input  logic                 pf_blank_i,
    input  playfield_pkg::hres_t vid_left_i,
    input  playfield_pkg::hres_t vid_right_i,
    input  playfield_pkg::addr_t pf_start_addr_i,
    input  playfield_pkg::word_t pf_line_len_i,
    input  logic [1:0]           pf_v_repeat_i,
    output playfield_pkg::addr_t line_addr_o,
    output logic                 addr_load_o,
    output logic                 line_start_o,
    output logic                 scanout_on_o
);
    import playfield_pkg::*;

    addr_t      line_start;                             // first word of current line
    logic [1:0] v_cnt;                                  // lines left to repeat
    hres_t      start_hcount;
    hres_t      end_hcount;
    logic       restart;                                // back to frame start

    assign restart      = pf_blank_i || end_of_frame_i;
    assign line_addr_o  = restart ? pf_start_addr_i : line_start;
    assign addr_load_o  = restart || end_of_line_i || mem_fetch_start_i;
    assign line_start_o = mem_fetch_start_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start   <= '0;
            v_cnt        <= '0;
            start_hcount <= '0;
            end_hcount   <= '0;
            scanout_on_o <= 1'b0;
        end else begin
            if (h_count_i == start_hcount && mem_fetch_i) begin
                scanout_on_o <= 1'b1;
            end
            if (h_count_i >= end_hcount) begin
                scanout_on_o <= 1'b0;                   // right edge reached
            end
            if (end_of_line_i) begin
                scanout_on_o <= 1'b0;
                if (v_cnt != 2'd0) begin
                    v_cnt <= v_cnt - 1'b1;              // same line again
                end else begin
                    v_cnt      <= pf_v_repeat_i;
                    line_start <= line_start + pf_line_len_i;
                end
                start_hcount <= H_SCANOUT_BEGIN + vid_left_i;
                end_hcount   <= H_SCANOUT_BEGIN + vid_right_i;
            end
            if (restart) begin
                line_start   <= pf_start_addr_i;
                v_cnt        <= pf_v_repeat_i;
                scanout_on_o <= 1'b0;
            end
        end
    end

endmodule

/* rtl/pixel_expand.sv */
`timescale 1ns/1ps

module pixel_expand (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [1:0]             pf_bpp_i,
    input  logic                   words_ready_i,
    input  playfield_pkg::word_t   attr_word_i,
    input  playfield_pkg::word_t   data_word0_i,
    input  playfield_pkg::word_t   data_word1_i,
    input  playfield_pkg::word_t   data_word2_i,
    input  playfield_pkg::word_t   data_word3_i,
    input  logic                   line_start_i,
    input  logic                   buf_take_i,          // scanout loaded the buffer
    output logic                   buf_full_o,
    output playfield_pkg::pixels_t pixels_buf_o
);
    import playfield_pkg::*;

    logic [3:0]  fore;                                  // 1 bpp set-bit color
    logic [3:0]  back;                                  // clear-bit color / color extension
    logic [31:0] nib_words;                             // 4 bpp source, leftmost pixel on top
    logic [63:0] byte_words;                            // 8 bpp source
    pixels_t     expanded;

    assign fore       = attr_word_i[ATTR_FORE +: 4];
    assign back       = attr_word_i[ATTR_BACK +: 4];
    assign nib_words  = {data_word0_i, data_word1_i};
    assign byte_words = {data_word0_i, data_word1_i, data_word2_i, data_word3_i};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (pf_bpp_i)
                BPP_1_ATTR: expanded[i*8 +: 8] = {4'h0, data_word0_i[i] ? fore : back};
                BPP_4:      expanded[i*8 +: 8] = {back, nib_words[i*4 +: 4]};
                default:    expanded[i*8 +: 8] = byte_words[i*8 +: 8] ^ {back, 4'h0}; // BPP_8
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full_o   <= 1'b0;
            pixels_buf_o <= '0;
        end else begin
            if (words_ready_i) begin
                buf_full_o   <= 1'b1;
                pixels_buf_o <= expanded;
            end
            if (buf_take_i || line_start_i) begin
                buf_full_o <= 1'b0;                     // new line discards leftovers
            end
        end
    end

endmodule

/* rtl/bitmap_fetch.sv */
`timescale 1ns/1ps

module bitmap_fetch (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 stall_i,               // hold everything this cycle
    input  logic                 pf_blank_i,
    input  logic [1:0]           pf_bpp_i,
    input  logic                 buf_full_i,            // pixel buffer still unread
    input  logic                 line_start_i,
    input  logic                 end_of_line_i,
    input  logic                 addr_load_i,
    input  playfield_pkg::addr_t line_addr_i,
    input  playfield_pkg::word_t vram_data_i,
    output logic                 vram_sel_o,
    output playfield_pkg::addr_t vram_addr_o,
    output logic                 words_ready_o,         // previous group complete
    output playfield_pkg::word_t attr_word_o,
    output playfield_pkg::word_t data_word0_o,
    output playfield_pkg::word_t data_word1_o,
    output playfield_pkg::word_t data_word2_o,
    output playfield_pkg::word_t data_word3_o
);
    import playfield_pkg::*;

    fetch_state_t state;
    addr_t        pf_addr;                              // next display word to read
    logic         initial_buf;                          // first group of line, nothing to hand over
    logic         rd_req;                               // issue a vram read this state

    // one read per state, depth decides how many follow the first
    always_comb begin
        rd_req = 1'b0;
        case (state)
            FETCH_ADDR:   rd_req = !buf_full_i;
            FETCH_WAIT:   rd_req = (pf_bpp_i != BPP_1_ATTR);
            FETCH_READ_0: rd_req = (pf_bpp_i != BPP_1_ATTR) && (pf_bpp_i != BPP_4);
            FETCH_READ_1: rd_req = (pf_bpp_i != BPP_1_ATTR) && (pf_bpp_i != BPP_4);
            default:      rd_req = 1'b0;
        endcase
        rd_req = rd_req && !pf_blank_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            pf_addr       <= '0;
            vram_sel_o    <= 1'b0;
            vram_addr_o   <= '0;
            initial_buf   <= 1'b0;
            words_ready_o <= 1'b0;
        end else begin
            words_ready_o <= 1'b0;                      // single cycle pulse
            if (!stall_i) begin
                vram_sel_o <= rd_req;
                if (rd_req) begin
                    vram_addr_o <= pf_addr;
                    pf_addr     <= pf_addr + 1'b1;
                end
                case (state)
                    FETCH_IDLE: state <= FETCH_ADDR;
                    FETCH_ADDR: begin
                        if (!buf_full_i) begin
                            state <= FETCH_WAIT;        // wait here for room in buffer
                        end
                    end
                    FETCH_WAIT: begin
                        words_ready_o <= !initial_buf;  // hand over last group's words
                        initial_buf   <= 1'b0;
                        state         <= FETCH_READ_0;
                    end
                    FETCH_READ_0: begin
                        data_word0_o <= vram_data_i;
                        attr_word_o  <= vram_data_i;    // 1 bpp word carries its own colors
                        state <= (pf_bpp_i == BPP_1_ATTR) ? FETCH_ADDR : FETCH_READ_1;
                    end
                    FETCH_READ_1: begin
                        data_word1_o     <= vram_data_i;
                        attr_word_o[15:8] <= 8'h00;     // no color extension in 4/8 bpp
                        state <= (pf_bpp_i == BPP_4) ? FETCH_ADDR : FETCH_READ_2;
                    end
                    FETCH_READ_2: begin
                        data_word2_o <= vram_data_i;
                        state        <= FETCH_READ_3;
                    end
                    FETCH_READ_3: begin
                        data_word3_o <= vram_data_i;
                        state        <= FETCH_ADDR;
                    end
                    default: state <= FETCH_IDLE;
                endcase
            end
            if (line_start_i) begin
                initial_buf <= 1'b1;
            end
            if (addr_load_i) begin
                pf_addr <= line_addr_i;                 // overrides the increment above
            end
            if (end_of_line_i || pf_blank_i) begin
                state <= FETCH_IDLE;
            end
            if (pf_blank_i) begin
                vram_sel_o <= 1'b0;                     // blank wins over stall hold
            end
        end
    end

endmodule

/* rtl/playfield_pkg.sv */
package playfield_pkg;

    typedef logic [15:0] word_t;                    // vram data word
    typedef logic [15:0] addr_t;                    // vram word address
    typedef logic [7:0]  color_t;                   // color index
    typedef logic [10:0] hres_t;                    // horizontal counter
    typedef logic [63:0] pixels_t;                  // eight color indices, leftmost in top byte

    // bitmap depth codes, code 3 decodes as 8 bpp
    localparam logic [1:0] BPP_1_ATTR = 2'd0;       // 1 bpp with attribute word
    localparam logic [1:0] BPP_4      = 2'd1;       // 4 bpp, two words per group
    localparam logic [1:0] BPP_8      = 2'd2;       // 8 bpp, four words per group

    localparam int ATTR_FORE = 8;                   // foreground nibble in attribute word
    localparam int ATTR_BACK = 12;                  // background / color extension nibble

    localparam int    OFFSCREEN_WIDTH = 160;        // offscreen pixels ahead of visible area
    localparam hres_t H_SCANOUT_BEGIN = hres_t'(OFFSCREEN_WIDTH - 2);   // scanout lead

    typedef enum logic [2:0] {
        FETCH_IDLE,                                 // waiting for line / unblank
        FETCH_ADDR,                                 // first read of a group
        FETCH_WAIT,                                 // second read issued, word 0 in flight
        FETCH_READ_0,                               // sample word 0
        FETCH_READ_1,                               // sample word 1
        FETCH_READ_2,                               // sample word 2
        FETCH_READ_3                                // sample word 3
    } fetch_state_t;

endpackage
